// File: hw/rob_cfg_pkg.sv
`default_nettype none

package rob_cfg_pkg;

    // ----------------------------------------
    // Reorder buffer sizing
    // ----------------------------------------
    // Entries, single thread
    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);
    // Count from 0 to ROB_DEPTH
    localparam int ROB_CNT_W = $clog2(ROB_DEPTH + 1);

    // Dispatch and retire widths
    localparam int DP_WIDTH = 2;
    localparam int DP_CNT_W = $clog2(DP_WIDTH + 1);
    localparam int RT_WIDTH = 2;
    localparam int RT_CNT_W = $clog2(RT_WIDTH + 1);

    // Result broadcast channels
    localparam int CDB_NUM = 2;

    // ----------------------------------------
    // Surrounding core
    // ----------------------------------------
    localparam int ARCH_REG_W = 5;
    localparam int PHY_TAG_W  = 6;
    localparam int XLEN       = 32;

    // Entry index plus offset, wraps at ROB_DEPTH
    function automatic logic [ROB_IDX_W-1:0] rob_idx_add(
        input logic [ROB_IDX_W-1:0] base,
        input logic [ROB_CNT_W-1:0] ofs
    );
        logic [ROB_CNT_W:0] sum;
        sum = (ROB_CNT_W+1)'(base) + (ROB_CNT_W+1)'(ofs);
        if (sum >= (ROB_CNT_W+1)'(ROB_DEPTH)) begin
            sum = sum - (ROB_CNT_W+1)'(ROB_DEPTH);
        end
        return sum[ROB_IDX_W-1:0];
    endfunction

endpackage

`default_nettype wire

// File: hw/rob_types_pkg.sv
`default_nettype none

package rob_types_pkg;

    import rob_cfg_pkg::*;

    // ----------------------------------------
    // Dispatch side
    // ----------------------------------------
    // One new instruction
    typedef struct packed {
        logic [ARCH_REG_W-1:0] rd;
        logic [PHY_TAG_W-1:0]  tag;
        logic [PHY_TAG_W-1:0]  tag_old;
        logic                  br_predict;
    } dp_slot_t;

    // Up to DP_WIDTH instructions, oldest in slot 0
    typedef struct packed {
        logic [DP_CNT_W-1:0]     num;
        dp_slot_t [DP_WIDTH-1:0] slot;
    } dp_req_t;

    // Free count and entry index per slot
    typedef struct packed {
        logic [DP_CNT_W-1:0]                avail_num;
        logic [DP_WIDTH-1:0][ROB_IDX_W-1:0] rob_idx;
    } dp_rsp_t;

    // ----------------------------------------
    // Broadcast and storage
    // ----------------------------------------
    typedef struct packed {
        logic                 valid;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic                 br_result;
        logic [XLEN-1:0]      br_target;
    } cdb_t;

    typedef struct packed {
        logic                  valid;
        logic                  complete;
        logic [ARCH_REG_W-1:0] rd;
        logic [PHY_TAG_W-1:0]  tag;
        logic [PHY_TAG_W-1:0]  tag_old;
        logic                  br_predict;
        logic                  br_result;
        logic [XLEN-1:0]       br_target;
    } rob_entry_t;

    // ----------------------------------------
    // Retire side
    // ----------------------------------------
    // Map table update and freed tag
    typedef struct packed {
        logic                  wr_en;
        logic [ARCH_REG_W-1:0] arch_reg;
        logic [PHY_TAG_W-1:0]  tag;
        logic [PHY_TAG_W-1:0]  tag_old;
    } rt_slot_t;

    typedef struct packed {
        logic [RT_CNT_W-1:0]     rt_num;
        rt_slot_t [RT_WIDTH-1:0] slot;
    } rt_out_t;

endpackage

`default_nettype wire

// File: hw/rob_ptr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rob_ptr_ctrl (
    input  wire logic                               clk_i,
    input  wire logic                               rst_i,
    input  wire logic                               flush_i,
    input  wire logic [rob_cfg_pkg::DP_CNT_W-1:0]   dp_num_i,
    input  wire logic [rob_cfg_pkg::RT_CNT_W-1:0]   rt_num_i,
    output logic      [rob_cfg_pkg::ROB_IDX_W-1:0]  head_o,
    output logic      [rob_cfg_pkg::ROB_IDX_W-1:0]  tail_o,
    output rob_types_pkg::dp_rsp_t                  dp_rsp_o
);

    import rob_cfg_pkg::*;

    logic [ROB_IDX_W-1:0] head_q;
    logic [ROB_IDX_W-1:0] tail_q;
    // Toggle on every pass through the last entry
    logic                 head_wrap_q;
    logic                 tail_wrap_q;
    logic [ROB_CNT_W:0]   head_sum;
    logic [ROB_CNT_W:0]   tail_sum;
    logic [ROB_CNT_W-1:0] empty_cnt;
    logic [ROB_CNT_W:0]   avail_cnt;

    // ----------------------------------------
    // Pointer update
    // ----------------------------------------
    // Unwrapped sums, used for wrap detection
    assign head_sum = (ROB_CNT_W+1)'(head_q) + (ROB_CNT_W+1)'(rt_num_i);
    assign tail_sum = (ROB_CNT_W+1)'(tail_q) + (ROB_CNT_W+1)'(dp_num_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head_q      <= '0;
            tail_q      <= '0;
            head_wrap_q <= 1'b0;
            tail_wrap_q <= 1'b0;
        end else if (flush_i) begin
            // Flush drops everything in flight
            head_q      <= '0;
            tail_q      <= '0;
            head_wrap_q <= 1'b0;
            tail_wrap_q <= 1'b0;
        end else begin
            head_q <= rob_idx_add(head_q, ROB_CNT_W'(rt_num_i));
            tail_q <= rob_idx_add(tail_q, ROB_CNT_W'(dp_num_i));
            if (head_sum >= (ROB_CNT_W+1)'(ROB_DEPTH)) begin
                head_wrap_q <= ~head_wrap_q;
            end
            if (tail_sum >= (ROB_CNT_W+1)'(ROB_DEPTH)) begin
                tail_wrap_q <= ~tail_wrap_q;
            end
        end
    end

    assign head_o = head_q;
    assign tail_o = tail_q;

    // ----------------------------------------
    // Free count and slot indices
    // ----------------------------------------
    always_comb begin
        // Same lap: used = tail - head
        // Tail one lap ahead: empty = head - tail
        if (head_wrap_q == tail_wrap_q) begin
            empty_cnt = ROB_CNT_W'(ROB_DEPTH) - (ROB_CNT_W'(tail_q) - ROB_CNT_W'(head_q));
        end else begin
            empty_cnt = ROB_CNT_W'(head_q) - ROB_CNT_W'(tail_q);
        end

        // Entries retiring now are reusable at the same edge
        avail_cnt = (ROB_CNT_W+1)'(empty_cnt) + (ROB_CNT_W+1)'(rt_num_i);
        if (avail_cnt > (ROB_CNT_W+1)'(DP_WIDTH)) begin
            dp_rsp_o.avail_num = DP_CNT_W'(DP_WIDTH);
        end else begin
            dp_rsp_o.avail_num = avail_cnt[DP_CNT_W-1:0];
        end

        // Slot k lands at tail + k
        for (int k = 0; k < DP_WIDTH; k++) begin
            dp_rsp_o.rob_idx[k] = rob_idx_add(tail_q, ROB_CNT_W'(k));
        end
    end

endmodule

`default_nettype wire

// File: hw/rob_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

module rob_entry_array (
    input  wire logic                                        clk_i,
    input  wire logic                                        rst_i,
    input  wire logic                                        flush_i,
    input  wire logic [rob_cfg_pkg::ROB_IDX_W-1:0]           tail_i,
    input  wire rob_types_pkg::dp_req_t                      dp_req_i,
    input  wire rob_types_pkg::cdb_t [rob_cfg_pkg::CDB_NUM-1:0] cdb_i,
    input  wire logic [rob_cfg_pkg::ROB_DEPTH-1:0]           rt_sel_i,
    output rob_types_pkg::rob_entry_t [rob_cfg_pkg::ROB_DEPTH-1:0] entries_o
);

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    // Control bits
    logic [ROB_DEPTH-1:0]     valid_q;
    logic [ROB_DEPTH-1:0]     complete_q;
    // Payload
    dp_slot_t [ROB_DEPTH-1:0] slot_q;
    logic [ROB_DEPTH-1:0]     result_q;
    logic [XLEN-1:0]          target_q [ROB_DEPTH];

    logic [ROB_IDX_W-1:0]     dp_idx [DP_WIDTH];
    logic [ROB_DEPTH-1:0]     dp_sel;
    dp_slot_t [ROB_DEPTH-1:0] dp_data;
    logic [ROB_DEPTH-1:0]     cp_sel;
    logic [ROB_DEPTH-1:0]     cp_result;
    logic [XLEN-1:0]          cp_target [ROB_DEPTH];

    // ----------------------------------------
    // Dispatch and broadcast decode
    // ----------------------------------------
    // Target entry of each dispatch slot, wraps past the end
    always_comb begin
        for (int k = 0; k < DP_WIDTH; k++) begin
            dp_idx[k] = rob_idx_add(tail_i, ROB_CNT_W'(k));
        end
    end

    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            dp_sel[i]    = 1'b0;
            dp_data[i]   = '0;
            cp_sel[i]    = 1'b0;
            cp_result[i] = 1'b0;
            cp_target[i] = '0;

            // Covered by this dispatch
            for (int k = 0; k < DP_WIDTH; k++) begin
                if ((DP_CNT_W'(k) < dp_req_i.num) && (dp_idx[k] == ROB_IDX_W'(i))) begin
                    dp_sel[i]  = 1'b1;
                    dp_data[i] = dp_req_i.slot[k];
                end
            end

            // Later channel overrides, so the higher one wins
            for (int c = 0; c < CDB_NUM; c++) begin
                if (cdb_i[c].valid && (cdb_i[c].rob_idx == ROB_IDX_W'(i))) begin
                    cp_sel[i]    = 1'b1;
                    cp_result[i] = cdb_i[c].br_result;
                    cp_target[i] = cdb_i[c].br_target;
                end
            end
        end
    end

    // ----------------------------------------
    // Entry state
    // ----------------------------------------
    // Priority: flush, dispatch, retire, complete
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            valid_q    <= '0;
            complete_q <= '0;
        end else begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (dp_sel[i]) begin
                    valid_q[i]    <= 1'b1;
                    complete_q[i] <= 1'b0;
                end else if (rt_sel_i[i]) begin
                    valid_q[i]    <= 1'b0;
                    complete_q[i] <= 1'b0;
                end else if (cp_sel[i] && valid_q[i]) begin
                    complete_q[i] <= 1'b1;
                end
            end
        end
    end

    // Payload only matters while valid
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (dp_sel[i]) begin
                slot_q[i] <= dp_data[i];
            end else if (cp_sel[i] && valid_q[i]) begin
                result_q[i] <= cp_result[i];
                target_q[i] <= cp_target[i];
            end
        end
    end

    // Pack into the entry view
    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            entries_o[i].valid      = valid_q[i];
            entries_o[i].complete   = complete_q[i];
            entries_o[i].rd         = slot_q[i].rd;
            entries_o[i].tag        = slot_q[i].tag;
            entries_o[i].tag_old    = slot_q[i].tag_old;
            entries_o[i].br_predict = slot_q[i].br_predict;
            entries_o[i].br_result  = result_q[i];
            entries_o[i].br_target  = target_q[i];
        end
    end

endmodule

`default_nettype wire

// File: hw/rob_retire_sel.sv
`timescale 1ns/1ps
`default_nettype none

module rob_retire_sel (
    input  wire logic [rob_cfg_pkg::ROB_IDX_W-1:0]                  head_i,
    input  wire rob_types_pkg::rob_entry_t [rob_cfg_pkg::ROB_DEPTH-1:0] entries_i,
    input  wire logic                                               exception_i,
    output logic      [rob_cfg_pkg::ROB_DEPTH-1:0]                  rt_sel_o,
    output logic      [rob_cfg_pkg::RT_CNT_W-1:0]                   rt_num_o,
    output logic                                                    flush_o,
    output rob_types_pkg::rt_out_t                                  rt_o,
    output logic                                                    br_mis_valid_o,
    output logic      [rob_cfg_pkg::XLEN-1:0]                       br_target_o
);

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    logic [ROB_IDX_W-1:0]       win_idx [RT_WIDTH];
    rob_entry_t [RT_WIDTH-1:0]  win;
    logic [RT_WIDTH-1:0]        win_mis;
    logic [RT_WIDTH-1:0]        lane_sel;

    // ----------------------------------------
    // Retire window
    // ----------------------------------------
    // RT_WIDTH entries starting at head
    always_comb begin
        for (int k = 0; k < RT_WIDTH; k++) begin
            win_idx[k] = rob_idx_add(head_i, ROB_CNT_W'(k));
            win[k]     = entries_i[win_idx[k]];
            // Predicted direction differs from resolved one
            win_mis[k] = win[k].br_predict != win[k].br_result;
        end
    end

    // In-order pick, stops after a mispredicted branch
    always_comb begin
        // Exception takes the whole window, nothing retires
        lane_sel[0] = win[0].valid & win[0].complete & ~exception_i;
        for (int k = 1; k < RT_WIDTH; k++) begin
            lane_sel[k] = lane_sel[k-1] & ~win_mis[k-1] & win[k].valid & win[k].complete;
        end
    end

    // ----------------------------------------
    // Count, entry select, misprediction
    // ----------------------------------------
    always_comb begin
        rt_sel_o       = '0;
        rt_num_o       = '0;
        br_mis_valid_o = 1'b0;
        br_target_o    = '0;
        for (int k = 0; k < RT_WIDTH; k++) begin
            if (lane_sel[k]) begin
                rt_sel_o[win_idx[k]] = 1'b1;
                rt_num_o             = rt_num_o + RT_CNT_W'(1);
                if (win_mis[k]) begin
                    br_mis_valid_o = 1'b1;
                    br_target_o    = win[k].br_target;
                end
            end
        end
    end

    // Either cause empties the buffer at the next edge
    assign flush_o = br_mis_valid_o | exception_i;

    // ----------------------------------------
    // Retire lanes
    // ----------------------------------------
    // Idle lanes driven to zero
    always_comb begin
        rt_o.rt_num = rt_num_o;
        for (int k = 0; k < RT_WIDTH; k++) begin
            rt_o.slot[k].wr_en = lane_sel[k];
            if (lane_sel[k]) begin
                rt_o.slot[k].arch_reg = win[k].rd;
                rt_o.slot[k].tag      = win[k].tag;
                rt_o.slot[k].tag_old  = win[k].tag_old;
            end else begin
                rt_o.slot[k].arch_reg = '0;
                rt_o.slot[k].tag      = '0;
                rt_o.slot[k].tag_old  = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  wire logic                                           clk_i,
    input  wire logic                                           rst_i,
    input  wire rob_types_pkg::dp_req_t                         dp_req_i,
    output rob_types_pkg::dp_rsp_t                              dp_rsp_o,
    input  wire rob_types_pkg::cdb_t [rob_cfg_pkg::CDB_NUM-1:0] cdb_i,
    output rob_types_pkg::rt_out_t                              rt_o,
    input  wire logic                                           exception_i,
    output logic                                                br_mis_valid_o,
    output logic      [rob_cfg_pkg::XLEN-1:0]                   br_target_o
);

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------
    logic [ROB_IDX_W-1:0]       head;
    logic [ROB_IDX_W-1:0]       tail;
    rob_entry_t [ROB_DEPTH-1:0] entries;
    // Retire feedback
    logic [ROB_DEPTH-1:0]       rt_sel;
    logic [RT_CNT_W-1:0]        rt_num;
    // Misprediction or exception
    logic                       flush;

    // Pointers and free count
    rob_ptr_ctrl u_ptr_ctrl (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .flush_i  (flush),
        .dp_num_i (dp_req_i.num),
        .rt_num_i (rt_num),
        .head_o   (head),
        .tail_o   (tail),
        .dp_rsp_o (dp_rsp_o)
    );

    // Entry storage
    rob_entry_array u_entry_array (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .flush_i   (flush),
        .tail_i    (tail),
        .dp_req_i  (dp_req_i),
        .cdb_i     (cdb_i),
        .rt_sel_i  (rt_sel),
        .entries_o (entries)
    );

    // Retire and branch recovery
    rob_retire_sel u_retire_sel (
        .head_i         (head),
        .entries_i      (entries),
        .exception_i    (exception_i),
        .rt_sel_o       (rt_sel),
        .rt_num_o       (rt_num),
        .flush_o        (flush),
        .rt_o           (rt_o),
        .br_mis_valid_o (br_mis_valid_o),
        .br_target_o    (br_target_o)
    );

endmodule

`default_nettype wire

// File: sim/rob_props.sv
`timescale 1ns/1ps
`default_nettype none

module rob_props (
    input wire logic                   clk_i,
    input wire logic                   rst_i,
    input wire logic                   flush_i,
    input wire rob_types_pkg::dp_req_t dp_req_i,
    input wire rob_types_pkg::dp_rsp_t dp_rsp_i,
    input wire rob_types_pkg::rt_out_t rt_i,
    input wire logic                   br_mis_valid_i
);

    import rob_cfg_pkg::*;

    // First cycle out of reset retires nothing
    assert property (@(posedge clk_i) $fell(rst_i) |-> rt_i.rt_num == '0)
        else $error("retire count nonzero right after reset");

    // Dispatch stays within the offered space
    assert property (@(posedge clk_i) disable iff (rst_i)
        dp_req_i.num <= dp_rsp_i.avail_num)
        else $error("dispatch count above free count");

    // Mispredict only comes with a retiring branch
    assert property (@(posedge clk_i) disable iff (rst_i)
        br_mis_valid_i |-> rt_i.rt_num != '0)
        else $error("mispredict flagged with nothing retiring");

    // Empty buffer after any flush
    assert property (@(posedge clk_i) disable iff (rst_i)
        flush_i |=> dp_rsp_i.avail_num == DP_CNT_W'(DP_WIDTH))
        else $error("free count not at dispatch width after flush");

endmodule

`default_nettype wire

// File: sim/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    localparam int NUM_CYCLES   = 3000;
    localparam int RESET_CYCLES = 10;
    // Whole run plus a margin
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES) * 10 + 1000;

    logic                  clk_i;
    logic                  rst_i;
    dp_req_t               dp_req_i;
    dp_rsp_t               dp_rsp_o;
    cdb_t [CDB_NUM-1:0]    cdb_i;
    rt_out_t               rt_o;
    logic                  exception_i;
    logic                  br_mis_valid_o;
    logic [XLEN-1:0]       br_target_o;

    // Reference model entries live from m_head for m_count places
    dp_slot_t              m_slot [ROB_DEPTH];
    logic                  m_done [ROB_DEPTH];
    logic                  m_result [ROB_DEPTH];
    logic [XLEN-1:0]       m_target [ROB_DEPTH];
    int                    m_head;
    int                    m_tail;
    int                    m_count;

    // Stimulus of the current cycle and what it should produce
    dp_req_t               stim_dp;
    cdb_t [CDB_NUM-1:0]    stim_cdb;
    logic                  stim_exc;
    dp_rsp_t               exp_rsp;
    rt_out_t               exp_rt;
    int                    exp_rt_n;
    logic                  exp_mis;
    logic [XLEN-1:0]       exp_target;
    logic [31:0]           lfsr;

    rob_top uut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .dp_req_i       (dp_req_i),
        .dp_rsp_o       (dp_rsp_o),
        .cdb_i          (cdb_i),
        .rt_o           (rt_o),
        .exception_i    (exception_i),
        .br_mis_valid_o (br_mis_valid_o),
        .br_target_o    (br_target_o)
    );

    bind rob_top rob_props u_props (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .flush_i        (flush),
        .dp_req_i       (dp_req_i),
        .dp_rsp_i       (dp_rsp_o),
        .rt_i           (rt_o),
        .br_mis_valid_i (br_mis_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Random bits and failure exit
    // ----------------------------------------
    // One step per bit with taps 32 22 2 1
    function automatic logic [31:0] draw_bits(input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    function automatic logic in_flight(input int idx);
        return ((idx - m_head + ROB_DEPTH) % ROB_DEPTH) < m_count;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Expected outputs from model state and this cycle's exception
    task automatic predict_outputs();
        int   idx;
        int   free;
        logic open;
        exp_rt     = '0;
        exp_rt_n   = 0;
        exp_mis    = 1'b0;
        exp_target = '0;
        // Exception blocks retirement entirely
        open       = !stim_exc;
        for (int k = 0; k < RT_WIDTH; k++) begin
            idx = (m_head + k) % ROB_DEPTH;
            if (open && (k < m_count) && m_done[idx]) begin
                exp_rt.slot[k].wr_en    = 1'b1;
                exp_rt.slot[k].arch_reg = m_slot[idx].rd;
                exp_rt.slot[k].tag      = m_slot[idx].tag;
                exp_rt.slot[k].tag_old  = m_slot[idx].tag_old;
                exp_rt_n++;
                // Mispredicted branch closes the window
                if (m_slot[idx].br_predict != m_result[idx]) begin
                    exp_mis    = 1'b1;
                    exp_target = m_target[idx];
                    open       = 1'b0;
                end
            end else begin
                open = 1'b0;
            end
        end
        exp_rt.rt_num = RT_CNT_W'(exp_rt_n);
        free = ROB_DEPTH - m_count + exp_rt_n;
        if (free > DP_WIDTH) begin
            free = DP_WIDTH;
        end
        exp_rsp.avail_num = DP_CNT_W'(free);
        for (int k = 0; k < DP_WIDTH; k++) begin
            exp_rsp.rob_idx[k] = ROB_IDX_W'((m_tail + k) % ROB_DEPTH);
        end
    endtask

    // Edge update order is flush then broadcast then retire then dispatch
    task automatic model_step();
        int idx;
        if (stim_exc || exp_mis) begin
            m_head  = 0;
            m_tail  = 0;
            m_count = 0;
        end else begin
            for (int c = 0; c < CDB_NUM; c++) begin
                idx = int'(stim_cdb[c].rob_idx);
                if (stim_cdb[c].valid && in_flight(idx)) begin
                    m_done[idx]   = 1'b1;
                    m_result[idx] = stim_cdb[c].br_result;
                    m_target[idx] = stim_cdb[c].br_target;
                end
            end
            m_head  = (m_head + exp_rt_n) % ROB_DEPTH;
            m_count = m_count - exp_rt_n;
            for (int k = 0; k < int'(stim_dp.num); k++) begin
                m_slot[m_tail] = stim_dp.slot[k];
                m_done[m_tail] = 1'b0;
                m_tail         = (m_tail + 1) % ROB_DEPTH;
                m_count++;
            end
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic make_stimulus();
        int n_dp;
        int idx;
        // Roughly one cycle in 64
        stim_exc = (draw_bits(6) == 0);
        predict_outputs();
        n_dp = int'(draw_bits(2));
        if (n_dp > int'(exp_rsp.avail_num)) begin
            n_dp = int'(exp_rsp.avail_num);
        end
        stim_dp     = '0;
        stim_dp.num = DP_CNT_W'(n_dp);
        for (int k = 0; k < DP_WIDTH; k++) begin
            stim_dp.slot[k].rd         = ARCH_REG_W'(draw_bits(ARCH_REG_W));
            stim_dp.slot[k].tag        = PHY_TAG_W'(draw_bits(PHY_TAG_W));
            stim_dp.slot[k].tag_old    = PHY_TAG_W'(draw_bits(PHY_TAG_W));
            stim_dp.slot[k].br_predict = draw_bits(1) != 0;
        end
        // Each channel fires half the time so the buffer can fill up
        // Results mostly agree with the prediction
        for (int c = 0; c < CDB_NUM; c++) begin
            stim_cdb[c] = '0;
            if ((m_count > 0) && (draw_bits(1) != 0)) begin
                idx = (m_head + int'(draw_bits(4)) % m_count) % ROB_DEPTH;
                stim_cdb[c].valid     = 1'b1;
                stim_cdb[c].rob_idx   = ROB_IDX_W'(idx);
                stim_cdb[c].br_result = m_slot[idx].br_predict ^ (draw_bits(4) == 0);
                stim_cdb[c].br_target = draw_bits(XLEN);
            end
        end
        dp_req_i    <= stim_dp;
        cdb_i       <= stim_cdb;
        exception_i <= stim_exc;
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_rsp(input dp_rsp_t got, input dp_rsp_t want);
        if (got !== want) begin
            abort_run($sformatf("ERROR %0t: dispatch reply avail %0d idx %h, expected %0d idx %h",
                $time, got.avail_num, got.rob_idx, want.avail_num, want.rob_idx));
        end
    endtask

    task automatic check_retire(input rt_out_t got, input rt_out_t want);
        if (got.rt_num !== want.rt_num) begin
            abort_run($sformatf("ERROR %0t: retire count %0d, expected %0d",
                $time, got.rt_num, want.rt_num));
        end
        for (int k = 0; k < RT_WIDTH; k++) begin
            if ((got.slot[k].wr_en !== want.slot[k].wr_en)
                || (want.slot[k].wr_en && (got.slot[k] !== want.slot[k]))) begin
                abort_run($sformatf("ERROR %0t: retire lane %0d is %h, expected %h",
                    $time, k, got.slot[k], want.slot[k]));
            end
        end
    endtask

    task automatic check_branch(input logic got_v, input logic [XLEN-1:0] got_t,
                                input logic want_v, input logic [XLEN-1:0] want_t);
        if ((got_v !== want_v) || (got_t !== want_t)) begin
            abort_run($sformatf("ERROR %0t: mispredict %b target %h, expected %b target %h",
                $time, got_v, got_t, want_v, want_t));
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        lfsr        = 32'h2d7;
        stim_dp     = '0;
        stim_cdb    = '0;
        stim_exc    = 1'b0;
        m_head      = 0;
        m_tail      = 0;
        m_count     = 0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            m_done[i] = 1'b0;
        end
        rst_i       <= 1'b1;
        dp_req_i    <= '0;
        cdb_i       <= '0;
        exception_i <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        // Idle outputs right after reset
        predict_outputs();
        @(negedge clk_i);
        check_retire(rt_o, exp_rt);
        check_branch(br_mis_valid_o, br_target_o, exp_mis, exp_target);
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk_i);
            model_step();
            make_stimulus();
            // Outputs settled mid cycle
            @(negedge clk_i);
            check_rsp(dp_rsp_o, exp_rsp);
            check_retire(rt_o, exp_rt);
            check_branch(br_mis_valid_o, br_target_o, exp_mis, exp_target);
        end
        $display("TEST PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: rob.f
hw/rob_cfg_pkg.sv
hw/rob_types_pkg.sv
hw/rob_ptr_ctrl.sv
hw/rob_entry_array.sv
hw/rob_retire_sel.sv
hw/rob_top.sv
sim/rob_props.sv
sim/rob_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rob_tb -Mdir "$BUILD_DIR" -f rob.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/Vrob_tb" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "TEST FAILED" "$SIM_LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation finished without failure"
exit 0
